// ==== build.f ====
hw/rv_muldiv_pkg.sv
hw/rv_mul.sv
hw/rv_div.sv
hw/rv_muldiv_wb.sv
hw/rv_muldiv.sv
verif/rv_muldiv_props.sv
verif/rv_muldiv_tb.sv

// ==== hw/rv_div.sv ====
////////////////////////////////////////////////////////////
// rv div
// bit-serial restoring divider for DIV/DIVU/REM/REMU and W forms
// divide by zero and signed overflow resolve at issue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_div #(
  parameter int XLEN = 64
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           ex_stall,     // also holds while unit busy
  input  logic                           id_bubble,
  input  logic [rv_muldiv_pkg::ilen-1:0] id_instr,
  input  logic [XLEN-1:0]                opa,          // dividend
  input  logic [XLEN-1:0]                opb,          // divisor
  input  logic [1:0]                     st_xlen,
  output logic                           div_stall,
  output logic                           div_bubble,
  output logic [XLEN-1:0]                div_r
);

  localparam int cnt_bits = $clog2(XLEN);
  localparam logic [cnt_bits-1:0] cnt_full = cnt_bits'(XLEN - 1); // XLEN iterations
  localparam logic [cnt_bits-1:0] cnt_word = cnt_bits'(31);       // 32 iterations

  // fsm states
  localparam logic [1:0] st_chk = 2'd0;
  localparam logic [1:0] st_div = 2'd1;
  localparam logic [1:0] st_res = 2'd2;

  logic [1:0]          state;
  logic [cnt_bits-1:0] cnt;

  // decode
  logic [4:0]      opcode;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            w_ok;          // W forms legal in this mode
  logic            is_w;
  logic            is_div;
  logic            is_sgn;
  logic            is_rem;
  logic            issue;

  // operand prep
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic [XLEN-1:0] min_neg;
  logic            b_zero;
  logic            ovf;
  logic            special;
  logic [XLEN-1:0] spec_r;

  // datapath
  logic [XLEN-1:0] pa_p;          // partial remainder
  logic [XLEN-1:0] pa_a;          // dividend in, quotient out
  logic [XLEN-1:0] b;             // |divisor|
  logic            neg_q;
  logic            neg_r;
  logic            rem_sel;
  logic            w_sel;
  logic [XLEN:0]   shift_p;
  logic [XLEN+1:0] diff;
  logic            q_bit;
  logic [XLEN-1:0] q_fix;
  logic [XLEN-1:0] r_fix;
  logic [XLEN-1:0] res_raw;

  //////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////

  assign opcode = id_instr[6:2];
  assign f3     = id_instr[14:12];
  assign f7     = id_instr[31:25];

  assign w_ok   = (XLEN > 32) && (st_xlen == rv_muldiv_pkg::xlen_rv64i);
  assign is_w   = opcode == rv_muldiv_pkg::opc_op32;
  assign is_div = (f7 == rv_muldiv_pkg::funct7_muldiv) && f3[2] &&
                  (opcode == rv_muldiv_pkg::opc_op || (is_w && w_ok));
  assign is_sgn = (f3 == rv_muldiv_pkg::f3_div) || (f3 == rv_muldiv_pkg::f3_rem);
  assign is_rem = (f3 == rv_muldiv_pkg::f3_rem) || (f3 == rv_muldiv_pkg::f3_remu);
  assign issue  = !ex_stall && !id_bubble && is_div;

  //////////////////////////////////////////////////////////
  // operands and early results
  //////////////////////////////////////////////////////////

  always_comb begin
    if (is_w) begin
      a_ext = is_sgn ? XLEN'($signed(opa[31:0])) : XLEN'(opa[31:0]);
      b_ext = is_sgn ? XLEN'($signed(opb[31:0])) : XLEN'(opb[31:0]);
    end else begin
      a_ext = opa;
      b_ext = opb;
    end
  end

  assign a_neg   = is_sgn & a_ext[XLEN-1];
  assign b_neg   = is_sgn & b_ext[XLEN-1];
  assign a_abs   = a_neg ? -a_ext : a_ext;
  assign b_abs   = b_neg ? -b_ext : b_ext;

  assign min_neg = is_w ? XLEN'($signed(32'h8000_0000)) : {1'b1, {(XLEN-1){1'b0}}};
  assign b_zero  = b_ext == '0;
  assign ovf     = is_sgn && (a_ext == min_neg) && (&b_ext);   // -2^(n-1) / -1
  assign special = b_zero || ovf;

  always_comb begin
    if (b_zero)
      spec_r = is_rem ? (is_w ? XLEN'($signed(opa[31:0])) : opa)  // rem = dividend
                      : {XLEN{1'b1}};                              // q = all ones
    else
      spec_r = is_rem ? '0 : a_ext;                                // overflow case
  end

  //////////////////////////////////////////////////////////
  // restoring step and result fixup
  //////////////////////////////////////////////////////////

  // keep the bit shifted out of p, divisor may exceed 2^(XLEN-1)
  assign shift_p = {pa_p, pa_a[XLEN-1]};
  assign diff    = {1'b0, shift_p} - {2'b00, b};
  assign q_bit   = ~diff[XLEN+1];                    // no borrow, subtract stands

  assign q_fix   = neg_q ? -pa_a : pa_a;
  assign r_fix   = neg_r ? -pa_p : pa_p;              // rem follows dividend sign
  assign res_raw = rem_sel ? r_fix : q_fix;

  // fsm control
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= st_chk;
      cnt        <= '0;
      div_bubble <= 1'b1;
      div_stall  <= 1'b0;
    end else begin
      div_bubble <= 1'b1;                             // one cycle result strobe
      case (state)
        st_chk: if (issue) begin
          if (special) begin
            div_bubble <= 1'b0;                       // answer right away
          end else begin
            state     <= st_div;
            div_stall <= 1'b1;
            cnt       <= is_w ? cnt_word : cnt_full;
          end
        end
        st_div: begin                                 // ex_stall ignored here
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= st_res;
        end
        st_res: begin
          state      <= st_chk;
          div_bubble <= 1'b0;
          div_stall  <= 1'b0;
        end
        default: state <= st_chk;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      st_chk: if (issue) begin
        if (special) begin
          div_r <= spec_r;
        end else begin
          pa_p    <= '0;
          pa_a    <= is_w ? a_abs << (XLEN - 32) : a_abs;  // word dividend at top
          b       <= b_abs;
          neg_q   <= a_neg ^ b_neg;
          neg_r   <= a_neg;
          rem_sel <= is_rem;
          w_sel   <= is_w;
        end
      end
      st_div: begin
        pa_p <= q_bit ? diff[XLEN-1:0] : shift_p[XLEN-1:0];  // restore on borrow
        pa_a <= {pa_a[XLEN-2:0], q_bit};
      end
      st_res: div_r <= w_sel ? XLEN'($signed(res_raw[31:0])) : res_raw;
      default: ;
    endcase
  end

endmodule

// ==== hw/rv_mul.sv ====
////////////////////////////////////////////////////////////
// rv mul
// two-stage pipelined multiplier for MUL/MULH/MULHSU/MULHU/MULW
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_mul #(
  parameter int XLEN = 64
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           ex_stall,   // freezes both stages
  input  logic                           id_bubble,
  input  logic [rv_muldiv_pkg::ilen-1:0] id_instr,
  input  logic [XLEN-1:0]                opa,
  input  logic [XLEN-1:0]                opb,
  input  logic [1:0]                     st_xlen,
  output logic                           mul_bubble,
  output logic [XLEN-1:0]                mul_r
);

  // decode
  logic [4:0]              opcode;
  logic [2:0]              f3;
  logic                    is_m;
  logic                    w_ok;
  logic                    is_w;
  logic                    is_mul;
  logic                    a_sgn;
  logic                    b_sgn;

  // stage one
  logic                    s1_valid;
  logic signed [XLEN:0]    s1_a;        // one extra bit carries the sign
  logic signed [XLEN:0]    s1_b;
  logic                    s1_hi;       // upper half wanted
  logic                    s1_w;

  // stage two
  logic signed [2*XLEN+1:0] prod;
  logic [XLEN-1:0]          res;

  //////////////////////////////////////////////////////////
  // stage one, decode and extend
  //////////////////////////////////////////////////////////

  assign opcode = id_instr[6:2];
  assign f3     = id_instr[14:12];
  assign is_m   = (id_instr[31:25] == rv_muldiv_pkg::funct7_muldiv) && !f3[2];
  assign w_ok   = (XLEN > 32) && (st_xlen == rv_muldiv_pkg::xlen_rv64i);
  assign is_w   = (opcode == rv_muldiv_pkg::opc_op32) && w_ok &&
                  (f3 == rv_muldiv_pkg::f3_mul);       // MULW only
  assign is_mul = is_m && ((opcode == rv_muldiv_pkg::opc_op) || is_w);

  // signedness per variant, MUL low half does not care
  assign a_sgn  = (f3 == rv_muldiv_pkg::f3_mulh) || (f3 == rv_muldiv_pkg::f3_mulhsu);
  assign b_sgn  =  f3 == rv_muldiv_pkg::f3_mulh;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      s1_valid <= 1'b0;
    else if (!ex_stall)
      s1_valid <= !id_bubble && is_mul;
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      s1_a  <= {a_sgn & opa[XLEN-1], opa};
      s1_b  <= {b_sgn & opb[XLEN-1], opb};
      s1_hi <= f3 != rv_muldiv_pkg::f3_mul;
      s1_w  <= is_w;
    end
  end

  //////////////////////////////////////////////////////////
  // stage two, product and select
  //////////////////////////////////////////////////////////

  assign prod = s1_a * s1_b;                            // full signed product

  always_comb begin
    if (s1_w)
      res = XLEN'($signed(prod[31:0]));                 // low word, sign extended
    else if (s1_hi)
      res = prod[2*XLEN-1:XLEN];
    else
      res = prod[XLEN-1:0];
  end

  // result strobe lasts one cycle, a stall never repeats it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      mul_bubble <= 1'b1;
    else
      mul_bubble <= ex_stall || !s1_valid;
  end

  always_ff @(posedge clk) begin
    if (!ex_stall && s1_valid) mul_r <= res;            // held through a stall
  end

endmodule

// ==== hw/rv_muldiv.sv ====
////////////////////////////////////////////////////////////
// rv muldiv
// M extension execution unit, multiplier and divider merged
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_muldiv #(
  parameter int XLEN = 64
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           ex_stall,
  input  logic                           id_bubble,
  input  logic [rv_muldiv_pkg::ilen-1:0] id_instr,
  input  logic [XLEN-1:0]                opa,
  input  logic [XLEN-1:0]                opb,
  input  logic [1:0]                     st_xlen,
  output logic                           muldiv_bubble,
  output logic [XLEN-1:0]                muldiv_r,
  output logic                           muldiv_stall
);

  logic            mul_bubble;
  logic [XLEN-1:0] mul_r;
  logic            div_bubble;
  logic [XLEN-1:0] div_r;
  logic            div_stall;
  logic            unit_stall;

  // decode holds its instruction on our own stall, so no unit may take it
  assign unit_stall = ex_stall || muldiv_stall;

  rv_mul #(.XLEN(XLEN)) i_rv_mul (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (unit_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .opa        (opa),
    .opb        (opb),
    .st_xlen    (st_xlen),
    .mul_bubble (mul_bubble),
    .mul_r      (mul_r)
  );

  rv_div #(.XLEN(XLEN)) i_rv_div (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (unit_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .opa        (opa),
    .opb        (opb),
    .st_xlen    (st_xlen),
    .div_stall  (div_stall),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

  rv_muldiv_wb #(.XLEN(XLEN)) i_rv_muldiv_wb (
    .clk           (clk),
    .rstn          (rstn),
    .mul_bubble    (mul_bubble),
    .mul_r         (mul_r),
    .div_bubble    (div_bubble),
    .div_r         (div_r),
    .div_stall     (div_stall),
    .muldiv_bubble (muldiv_bubble),
    .muldiv_r      (muldiv_r),
    .muldiv_stall  (muldiv_stall)
  );

endmodule

// ==== hw/rv_muldiv_pkg.sv ====
////////////////////////////////////////////////////////////
// rv muldiv package
// instruction field patterns and mode codes for the M unit
////////////////////////////////////////////////////////////

package rv_muldiv_pkg;

  //////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////

  localparam int ilen = 32;                         // instruction word

  //////////////////////////////////////////////////////////
  // st_xlen mode codes
  //////////////////////////////////////////////////////////

  // same encoding as the misa mxl field
  localparam logic [1:0] xlen_rv32i = 2'b01;
  localparam logic [1:0] xlen_rv64i = 2'b10;

  //////////////////////////////////////////////////////////
  // major opcodes, instr[6:2]
  //////////////////////////////////////////////////////////

  localparam logic [4:0] opc_op   = 5'b01100;       // reg-reg ops
  localparam logic [4:0] opc_op32 = 5'b01110;       // word ops, rv64 only

  // funct7 that tags an OP/OP-32 as M extension
  localparam logic [6:0] funct7_muldiv = 7'b000_0001;

  //////////////////////////////////////////////////////////
  // funct3 of the M operations
  //////////////////////////////////////////////////////////

  // bit 2 splits multiply from divide
  localparam logic [2:0] f3_mul    = 3'b000;
  localparam logic [2:0] f3_mulh   = 3'b001;
  localparam logic [2:0] f3_mulhsu = 3'b010;
  localparam logic [2:0] f3_mulhu  = 3'b011;
  localparam logic [2:0] f3_div    = 3'b100;
  localparam logic [2:0] f3_divu   = 3'b101;
  localparam logic [2:0] f3_rem    = 3'b110;
  localparam logic [2:0] f3_remu   = 3'b111;

  // only MUL exists as a W form of the multiplies
  // all four divide ops have W forms

endpackage

// ==== hw/rv_muldiv_wb.sv ====
////////////////////////////////////////////////////////////
// rv muldiv writeback merge
// one result stream in issue order, parks a colliding divide
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_muldiv_wb #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            mul_bubble,
  input  logic [XLEN-1:0] mul_r,
  input  logic            div_bubble,
  input  logic [XLEN-1:0] div_r,
  input  logic            div_stall,
  output logic            muldiv_bubble,
  output logic [XLEN-1:0] muldiv_r,
  output logic            muldiv_stall
);

  logic            collide;       // both units finish this cycle
  logic            park_valid;
  logic [XLEN-1:0] park_r;
  logic            mrg_stall;

  // a collision is always mul issued first, then a early divide
  assign collide   = !mul_bubble && !div_bubble;
  assign mrg_stall = collide;     // hold decode while the park fills

  //////////////////////////////////////////////////////////
  // park buffer
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      park_valid <= 1'b0;
    else
      park_valid <= collide;                  // released the next cycle
  end

  always_ff @(posedge clk) begin
    if (collide) park_r <= div_r;
  end

  //////////////////////////////////////////////////////////
  // output mux
  //////////////////////////////////////////////////////////

  assign muldiv_bubble = !park_valid && mul_bubble && div_bubble;

  always_comb begin
    if (park_valid)
      muldiv_r = park_r;                      // parked divide goes out
    else if (!mul_bubble)
      muldiv_r = mul_r;                       // older result wins a tie
    else
      muldiv_r = div_r;
  end

  assign muldiv_stall = div_stall || mrg_stall;

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the rv_muldiv testbench with Verilator
# pass is decided by the pass line in sim.log

rm -f sim.log build.log
verilator --binary --timing --assert -f build.f --top-module rv_muldiv_tb \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vrv_muldiv_tb > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== verif/rv_muldiv_props.sv ====
////////////////////////////////////////////////////////////
// rv muldiv props
// protocol checks bound into the M unit top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_muldiv_props #(
  parameter int XLEN = 64
) (
  input logic            clk,
  input logic            rstn,
  input logic            div_stall,
  input logic            div_bubble,
  input logic            muldiv_bubble,
  input logic [XLEN-1:0] muldiv_r,
  input logic            muldiv_stall
);

  ////////////////////////////////////////////////////////////
  // reset values
  ////////////////////////////////////////////////////////////

  reset_idle: assert property (@(posedge clk)
    $rose(rstn) |-> muldiv_bubble && !muldiv_stall)
    else $error("bubble not high or stall not low coming out of reset");

  ////////////////////////////////////////////////////////////
  // result data
  ////////////////////////////////////////////////////////////

  result_known: assert property (@(posedge clk) disable iff (!rstn)
    !muldiv_bubble |-> !$isunknown(muldiv_r))
    else $error("result carries unknown bits while valid");

  ////////////////////////////////////////////////////////////
  // stall through a division
  ////////////////////////////////////////////////////////////

  // divider stall only drops together with its result
  div_stall_steady: assert property (@(posedge clk) disable iff (!rstn)
    (div_stall && div_bubble) |=> (div_stall || !div_bubble))
    else $error("divider stall dropped before its result came out");

  // merge stall lasts one cycle, parked result follows
  merge_stall_pulse: assert property (@(posedge clk) disable iff (!rstn)
    (muldiv_stall && !div_stall) |=> (!muldiv_bubble && !muldiv_stall))
    else $error("merge stall longer than one cycle or parked result missing");

  // no result while a division is still running
  no_early_div: assert property (@(posedge clk) disable iff (!rstn)
    (div_stall && $past(div_stall)) |-> div_bubble)
    else $error("divider produced a result in the middle of a division");

endmodule

// ==== verif/rv_muldiv_tb.sv ====
////////////////////////////////////////////////////////////
// rv muldiv testbench
// random and directed M ops against a queue of expected results
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_muldiv_tb;

  localparam int XLEN       = 64;
  localparam int max_cycles = 20000;   // ~200 ops x 66 cycles plus margin

  logic                           clk;
  logic                           rstn;
  logic                           ex_stall;
  logic                           id_bubble;
  logic [rv_muldiv_pkg::ilen-1:0] id_instr;
  logic [XLEN-1:0]                opa;
  logic [XLEN-1:0]                opb;
  logic [1:0]                     st_xlen;
  logic                           muldiv_bubble;
  logic [XLEN-1:0]                muldiv_r;
  logic                           muldiv_stall;

  // expected results in issue order
  logic [XLEN-1:0] exp_q[$];
  string           name_q[$];
  logic [XLEN-1:0] exp_head;
  string           head_name;
  int              exp_cnt;
  logic            pop_due;
  int              seed;
  int              cycles;

  rv_muldiv #(.XLEN(XLEN)) i_rv_muldiv (.*);

  bind rv_muldiv rv_muldiv_props #(.XLEN(XLEN)) i_rv_muldiv_props (
    .clk           (clk),
    .rstn          (rstn),
    .div_stall     (div_stall),
    .div_bubble    (div_bubble),
    .muldiv_bubble (muldiv_bubble),
    .muldiv_r      (muldiv_r),
    .muldiv_stall  (muldiv_stall)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // truncating division, remainder keeps the dividend sign
  function automatic logic [63:0] ref_div(input logic [2:0] f3, input logic w,
                                          input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [63:0]        q;
    logic [63:0]        r;
    logic [31:0]        q32;
    logic [31:0]        r32;
    logic               sgn;
    sgn = !f3[0];                       // DIV and REM are the signed ones
    sa  = a;
    sb  = b;
    wa  = a[31:0];
    wb  = b[31:0];
    if (w) begin
      if (wb == 32'sd0) begin
        q32 = '1;                       // all ones
        r32 = a[31:0];                  // dividend
      end else if (sgn && wa == 32'h8000_0000 && wb == -32'sd1) begin
        q32 = a[31:0];                  // overflow gives the dividend
        r32 = '0;
      end else if (sgn) begin
        q32 = wa / wb;
        r32 = wa % wb;
      end else begin
        q32 = a[31:0] / b[31:0];
        r32 = a[31:0] % b[31:0];
      end
      q = {{32{q32[31]}}, q32};         // W results sign extended
      r = {{32{r32[31]}}, r32};
    end else begin
      if (b == '0) begin
        q = '1;
        r = a;
      end else if (sgn && a == 64'h8000_0000_0000_0000 && sb == -64'sd1) begin
        q = a;
        r = '0;
      end else if (sgn) begin
        q = sa / sb;
        r = sa % sb;
      end else begin
        q = a / b;
        r = a % b;
      end
    end
    return f3[1] ? r : q;
  endfunction

  // signed products from the unsigned one by two's complement correction
  function automatic logic [63:0] ref_mul(input logic [2:0] f3, input logic w,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [127:0] pu;
    logic [127:0] ps;
    logic [127:0] psu;
    pu  = {64'b0, a} * {64'b0, b};
    psu = pu - (a[63] ? {b, 64'b0} : 128'b0);
    ps  = psu - (b[63] ? {a, 64'b0} : 128'b0);
    if (w) return {{32{pu[31]}}, pu[31:0]};
    case (f3)
      rv_muldiv_pkg::f3_mulh:   return ps[127:64];
      rv_muldiv_pkg::f3_mulhsu: return psu[127:64];
      rv_muldiv_pkg::f3_mulhu:  return pu[127:64];
      default:                  return pu[63:0];
    endcase
  endfunction

  task automatic refresh_head();
    exp_cnt = exp_q.size();
    if (exp_cnt != 0) begin
      exp_head  = exp_q[0];
      head_name = name_q[0];
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // result leaves the queue at the edge after it was seen
  always @(negedge clk) pop_due = rstn && !muldiv_bubble;

  always @(posedge clk) begin
    if (pop_due && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
      refresh_head();
    end
  end

  // outputs are stable at the falling edge
  check_value: assert property (@(negedge clk) disable iff (!rstn)
    (!muldiv_bubble && exp_cnt != 0) |-> muldiv_r == exp_head)
    else report_failure($sformatf("FAILED %s expected %h actual %h",
                                  head_name, exp_head, muldiv_r));

  check_extra: assert property (@(negedge clk) disable iff (!rstn)
    !muldiv_bubble |-> exp_cnt != 0)
    else report_failure("a result came out with no instruction waiting for it");

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles)
      report_failure("timeout, the run did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // drive one instruction, held until decode may move on
  task automatic issue(input string name, input logic [4:0] opc, input logic [2:0] f3,
                       input logic [63:0] a, input logic [63:0] b);
    logic w;
    w = opc == rv_muldiv_pkg::opc_op32;
    @(negedge clk);
    while (muldiv_stall) begin
      id_bubble = 1'b1;
      @(negedge clk);
    end
    id_instr  = {rv_muldiv_pkg::funct7_muldiv, 5'd2, 5'd1, f3, 5'd3, opc, 2'b11};
    opa       = a;
    opb       = b;
    id_bubble = 1'b0;                   // taken at the next rising edge
    if (!w || st_xlen == rv_muldiv_pkg::xlen_rv64i) begin
      exp_q.push_back(f3[2] ? ref_div(f3, w, a, b) : ref_mul(f3, w, a, b));
      name_q.push_back(name);
      refresh_head();
    end
  endtask

  task automatic idle(input int n);
    @(negedge clk);
    id_bubble = 1'b1;
    repeat (n - 1) @(negedge clk);
  endtask

  task automatic drain();
    idle(1);
    while (exp_cnt != 0) @(negedge clk);
  endtask

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [2:0]  f3;
    seed      = 9;
    cycles    = 0;
    exp_cnt   = 0;
    pop_due   = 1'b0;
    exp_head  = '0;
    head_name = "none";
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    opa       = '0;
    opb       = '0;
    st_xlen   = rv_muldiv_pkg::xlen_rv64i;
    repeat (4) @(posedge clk);
    @(negedge clk) rstn = 1'b1;

    // full width divides, divisor shortened now and then
    for (int i = 0; i < 40; i++) begin
      a  = rand64();
      b  = rand64() >> ($random(seed) & 63);
      f3 = {1'b1, 2'($random(seed))};
      issue("div_rand", rv_muldiv_pkg::opc_op, f3, a, b);
    end
    drain();

    // W forms in rv64 mode
    for (int i = 0; i < 20; i++) begin
      a  = rand64();
      b  = rand64() >> ($random(seed) & 31);
      f3 = {1'b1, 2'($random(seed))};
      issue("divw_rand", rv_muldiv_pkg::opc_op32, f3, a, b);
      issue("mulw_rand", rv_muldiv_pkg::opc_op32, rv_muldiv_pkg::f3_mul, a, b);
    end
    drain();

    // W forms ignored in rv32 mode
    st_xlen = rv_muldiv_pkg::xlen_rv32i;
    issue("divw_rv32", rv_muldiv_pkg::opc_op32, rv_muldiv_pkg::f3_div, rand64(), 64'd7);
    issue("mulw_rv32", rv_muldiv_pkg::opc_op32, rv_muldiv_pkg::f3_mul, rand64(), 64'd7);
    idle(40);
    st_xlen = rv_muldiv_pkg::xlen_rv64i;

    // divide by zero and signed overflow
    a = rand64();
    for (int k = 4; k < 8; k++) begin
      issue("div_zero", rv_muldiv_pkg::opc_op, 3'(k), a, 64'd0);
      issue("divw_zero", rv_muldiv_pkg::opc_op32, 3'(k), a, 64'hffff_ffff_0000_0000);
    end
    issue("div_ovf", rv_muldiv_pkg::opc_op, rv_muldiv_pkg::f3_div, 64'h8000_0000_0000_0000, '1);
    issue("rem_ovf", rv_muldiv_pkg::opc_op, rv_muldiv_pkg::f3_rem, 64'h8000_0000_0000_0000, '1);
    issue("divw_ovf", rv_muldiv_pkg::opc_op32, rv_muldiv_pkg::f3_div, 64'h8000_0000, '1);
    issue("remw_ovf", rv_muldiv_pkg::opc_op32, rv_muldiv_pkg::f3_rem, 64'h8000_0000, '1);
    issue("div_stall", rv_muldiv_pkg::opc_op, rv_muldiv_pkg::f3_divu, rand64(), 64'd3);
    drain();

    // multiplies back to back
    for (int i = 0; i < 30; i++) begin
      issue("mul_pair0", rv_muldiv_pkg::opc_op, {1'b0, 2'($random(seed))}, rand64(), rand64());
      issue("mul_pair1", rv_muldiv_pkg::opc_op, {1'b0, 2'($random(seed))}, rand64(), rand64());
    end
    drain();

    // multiply then early divide, both finish together
    for (int i = 0; i < 4; i++) begin
      issue("mul_collide", rv_muldiv_pkg::opc_op, 3'(i), rand64(), rand64());
      issue("div_collide", rv_muldiv_pkg::opc_op, rv_muldiv_pkg::f3_rem, rand64(), 64'd0);
      drain();
    end

    // freeze from later stages
    issue("mul_exstall", rv_muldiv_pkg::opc_op, rv_muldiv_pkg::f3_mulh, rand64(), rand64());
    @(negedge clk);
    id_bubble = 1'b1;
    ex_stall  = 1'b1;
    repeat (5) @(negedge clk);
    ex_stall  = 1'b0;
    drain();
    idle(10);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
